// File: source/sccb_pkg.sv
package sccb_pkg;

	// sequencer states
	typedef enum logic [2:0] {
		idle,
		start_cond,   // SIO_D falls at mid-high
		phase,        // nine bits of one byte
		stop_cond,    // SIO_D rises at mid-high
		restart_gap   // one spare bit between the two read passes
	} sccb_state_e;

	// which byte a phase carries
	typedef enum logic [1:0] {
		ph_id,        // device ID, bit 0 is the read flag
		ph_reg,       // register address
		ph_wdata,     // write data
		ph_rdata      // read data, driven by the slave
	} sccb_phase_e;

	// 8 data bits plus the don't-care / NA bit
	localparam int SCCB_PHASE_BITS = 9;

	// system clocks per quarter of a SIO_C period
	localparam int SCCB_CLK_DIV_DEF = 4;

endpackage

// File: source/sccb_phase_if.sv
`timescale 1ns/1ps

// byte level link between sequencer and shifter
interface sccb_phase_if (
	input logic sda_i  // resolved SIO_D from the pad
);
	import sccb_pkg::*;

	logic        load;        // start of a phase
	logic [7:0]  tx_byte;
	sccb_phase_e phase_kind;
	logic        shift;       // mid-low strobe
	logic        sample;      // mid-high strobe

	logic        sda_bit;     // bit currently on SIO_D
	logic        last_bit;    // high during the ninth bit
	logic        ack_bad;
	logic [7:0]  rx_byte;

	modport sequencer (
		output load, tx_byte, phase_kind, shift, sample,
		input  sda_bit, last_bit, ack_bad, rx_byte
	);

	modport shifter (
		input  load, tx_byte, phase_kind, shift, sample, sda_i,
		output sda_bit, last_bit, ack_bad, rx_byte
	);

endinterface

// File: source/sccb_bit_timer.sv
`timescale 1ns/1ps

// SIO_C generator
// one bit is four quarters of CLK_DIV clocks each: low, low, high, high
module sccb_bit_timer #(
	parameter int CLK_DIV = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic run_i,
	output logic sioc_o,
	output logic mid_low_o,
	output logic mid_high_o
);

	localparam int CW = $clog2(CLK_DIV);
	localparam logic [CW-1:0] CNT_LAST = CW'(CLK_DIV - 1);

	logic [CW-1:0] cnt;
	logic [1:0]    quarter;
	logic [1:0]    quarter_nxt;
	logic          q_end;

	assign q_end = (cnt == CNT_LAST);
	assign quarter_nxt = q_end ? quarter + 2'd1 : quarter;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt        <= '0;
			quarter    <= 2'd0;
			sioc_o     <= 1'b1;
			mid_low_o  <= 1'b0;
			mid_high_o <= 1'b0;
		end else if (!run_i) begin
			// stopped, so the next bit starts at quarter 0
			cnt        <= '0;
			quarter    <= 2'd0;
			sioc_o     <= 1'b1;
			mid_low_o  <= 1'b0;
			mid_high_o <= 1'b0;
		end else begin
			cnt        <= q_end ? '0 : cnt + CW'(1);
			quarter    <= quarter_nxt;
			sioc_o     <= quarter_nxt[1];                  // high in quarters 3 and 4
			mid_low_o  <= q_end && (quarter == 2'd0);     // middle of the low half
			mid_high_o <= q_end && (quarter == 2'd2);     // middle of the high half
		end
	end

endmodule

// File: source/sccb_shifter.sv
`timescale 1ns/1ps

// byte shifter for one nine bit phase
module sccb_shifter (
	input logic           clk,
	input logic           rst_n,
	sccb_phase_if.shifter bus
);
	import sccb_pkg::*;

	localparam logic [3:0] LAST_IDX = 4'(SCCB_PHASE_BITS - 1);

	logic [7:0] sh;        // outgoing byte, MSB first
	logic [3:0] bit_cnt;   // bits already presented in this phase
	logic       rx_phase;

	assign rx_phase = (bus.phase_kind == ph_rdata);

	// ones fill in from the right
	// so the ninth bit comes out as 1 (release or NA)
	always_ff @(posedge clk) begin
		if (bus.load) begin
			sh <= bus.tx_byte;
		end else if (bus.shift) begin
			sh <= {sh[6:0], 1'b1};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt      <= 4'd0;
			bus.sda_bit  <= 1'b1;
			bus.last_bit <= 1'b0;
			bus.ack_bad  <= 1'b0;
		end else begin
			// load leaves sda_bit alone until the first shift
			// SIO_C may still be high at that point
			if (bus.load) begin
				bit_cnt <= 4'd0;
			end else if (bus.shift) begin
				bit_cnt      <= bit_cnt + 4'd1;
				bus.sda_bit  <= sh[7];
				bus.last_bit <= (bit_cnt == LAST_IDX);
			end

			// ack slot of a transmitted byte
			if (bus.sample && bus.last_bit && !rx_phase) begin
				bus.ack_bad <= bus.sda_i;   // high means no ack
			end
		end
	end

	// read capture on the eight data bits only
	always_ff @(posedge clk) begin
		if (bus.sample && !bus.last_bit && rx_phase) begin
			bus.rx_byte <= {bus.rx_byte[6:0], bus.sda_i};
		end
	end

endmodule

// File: source/sccb_sequencer.sv
`timescale 1ns/1ps

// transfer control: start/stop conditions, phase order, done and ack error
// write: S ID REG DATA P
// read:  S ID REG P (gap) S ID|1 DATA(NA) P
module sccb_sequencer (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start_i,
	input  logic             rw_i,
	input  logic [7:0]       id_i,
	input  logic [7:0]       reg_i,
	input  logic [7:0]       wdata_i,
	input  logic             siod_i,
	input  logic             mid_low_i,
	input  logic             mid_high_i,
	output logic             run_o,
	output logic             siod_o,
	output logic             siod_oe_o,
	output logic             busy_o,
	output logic             done_o,
	output logic             ack_error_o,
	output logic [7:0]       rdata_o,
	sccb_phase_if.sequencer  bus
);
	import sccb_pkg::*;

	sccb_state_e state;
	sccb_phase_e cur_ph;
	sccb_phase_e nxt_ph;
	logic        nxt_stop;     // current phase is the last before a stop

	logic        accept;
	logic        rw_q;
	logic [7:0]  id_q;
	logic [7:0]  reg_q;
	logic [7:0]  wdata_q;
	logic        pass2;        // second half of a read

	logic        cond_lvl;     // SIO_D level outside of data bits
	logic        use_bit;      // SIO_D follows the shifter
	logic        rx_now;       // bit on the bus belongs to ph_rdata
	logic        load_q;
	logic        ack_chk;
	logic        bit9_done;

	assign accept    = start_i && (state == idle);
	assign run_o     = (state != idle);
	assign bit9_done = bus.sample && bus.last_bit;

	assign bus.load       = load_q;
	assign bus.phase_kind = cur_ph;
	assign bus.shift      = mid_low_i && (state == phase);
	assign bus.sample     = mid_high_i && (state == phase);

	// master lets go for the ack slot and for the read data bits
	assign siod_o    = use_bit ? bus.sda_bit : cond_lvl;
	assign siod_oe_o = use_bit ? (rx_now ? bus.last_bit : !bus.last_bit) : 1'b1;

	// phase that follows the current one
	always_comb begin
		nxt_ph   = cur_ph;
		nxt_stop = 1'b0;
		case (cur_ph)
			ph_id: begin
				nxt_ph = pass2 ? ph_rdata : ph_reg;
			end
			ph_reg: begin
				if (rw_q) begin
					nxt_stop = 1'b1;   // read restarts after the address
				end else begin
					nxt_ph = ph_wdata;
				end
			end
			default: begin
				nxt_stop = 1'b1;
			end
		endcase
	end

	always_comb begin
		case (cur_ph)
			ph_id:    bus.tx_byte = {id_q[7:1], pass2};
			ph_reg:   bus.tx_byte = reg_q;
			ph_wdata: bus.tx_byte = wdata_q;
			default:  bus.tx_byte = 8'hff;
		endcase
	end

	// request capture
	always_ff @(posedge clk) begin
		if (accept) begin
			id_q    <= id_i;
			reg_q   <= reg_i;
			wdata_q <= wdata_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= idle;
			cur_ph      <= ph_id;
			rw_q        <= 1'b0;
			pass2       <= 1'b0;
			cond_lvl    <= 1'b1;
			use_bit     <= 1'b0;
			rx_now      <= 1'b0;
			load_q      <= 1'b0;
			ack_chk     <= 1'b0;
			busy_o      <= 1'b0;
			done_o      <= 1'b0;
			ack_error_o <= 1'b0;
			rdata_o     <= 8'h00;
		end else begin
			load_q  <= 1'b0;
			done_o  <= 1'b0;
			ack_chk <= bit9_done && (cur_ph != ph_rdata);   // ack_bad valid next cycle

			if (ack_chk && bus.ack_bad) begin
				ack_error_o <= 1'b1;
			end

			if (bus.shift) begin
				use_bit <= 1'b1;
				rx_now  <= (cur_ph == ph_rdata);
			end

			case (state)
				idle: begin
					if (accept) begin
						state       <= start_cond;
						rw_q        <= rw_i;
						pass2       <= 1'b0;
						cond_lvl    <= 1'b1;
						busy_o      <= 1'b1;
						ack_error_o <= 1'b0;
					end
				end
				start_cond: begin
					if (mid_high_i) begin
						cond_lvl <= 1'b0;   // SIO_D falls with SIO_C high
						state    <= phase;
						cur_ph   <= ph_id;
						load_q   <= 1'b1;
						if (!siod_i) begin
							ack_error_o <= 1'b1;   // slave never released the line
						end
					end
				end
				phase: begin
					if (bit9_done) begin
						if (nxt_stop) begin
							state <= stop_cond;
						end else begin
							cur_ph <= nxt_ph;
							load_q <= 1'b1;
						end
					end
				end
				stop_cond: begin
					if (mid_low_i) begin
						use_bit  <= 1'b0;
						cond_lvl <= 1'b0;   // pull low while SIO_C is low
					end else if (mid_high_i) begin
						cond_lvl <= 1'b1;   // rising SIO_D is the stop
						if (rw_q && !pass2) begin
							state <= restart_gap;
							pass2 <= 1'b1;
						end else begin
							state  <= idle;
							busy_o <= 1'b0;
							done_o <= 1'b1;
							if (rw_q) begin
								rdata_o <= bus.rx_byte;
							end
						end
					end
				end
				restart_gap: begin
					if (mid_high_i) begin
						state <= start_cond;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

// File: source/sccb_master.sv
`timescale 1ns/1ps

// SCCB master, SIO_D split into in / out / output enable
module sccb_master #(
	parameter int CLK_DIV = sccb_pkg::SCCB_CLK_DIV_DEF
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start_i,
	input  logic       rw_i,        // 1 = read
	input  logic [7:0] id_i,
	input  logic [7:0] reg_i,
	input  logic [7:0] wdata_i,
	input  logic       siod_i,
	output logic       sioc_o,
	output logic       siod_o,
	output logic       siod_oe_o,
	output logic       busy_o,
	output logic       done_o,
	output logic       ack_error_o,
	output logic [7:0] rdata_o
);

	logic run;
	logic mid_low;
	logic mid_high;

	sccb_phase_if phase_bus (
		.sda_i (siod_i)
	);

	sccb_bit_timer #(
		.CLK_DIV (CLK_DIV)
	) u_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.run_i      (run),
		.sioc_o     (sioc_o),
		.mid_low_o  (mid_low),
		.mid_high_o (mid_high)
	);

	sccb_sequencer u_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.start_i     (start_i),
		.rw_i        (rw_i),
		.id_i        (id_i),
		.reg_i       (reg_i),
		.wdata_i     (wdata_i),
		.siod_i      (siod_i),
		.mid_low_i   (mid_low),
		.mid_high_i  (mid_high),
		.run_o       (run),
		.siod_o      (siod_o),
		.siod_oe_o   (siod_oe_o),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.ack_error_o (ack_error_o),
		.rdata_o     (rdata_o),
		.bus         (phase_bus.sequencer)
	);

	sccb_shifter u_shift (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (phase_bus.shifter)
	);

endmodule

// File: bench/sccb_master_chk.sv
`timescale 1ns/1ps

// bus protocol checks, bound into the sequencer
module sccb_master_chk (
	input logic                  clk,
	input logic                  rst_n,
	input sccb_pkg::sccb_state_e state_i,
	input sccb_pkg::sccb_phase_e phase_kind_i,
	input logic                  sioc_i,
	input logic                  busy_i,
	input logic                  done_i,
	input logic                  siod_oe_i,
	input logic                  sample_i,
	input logic                  last_bit_i
);
	import sccb_pkg::*;

	int fail_count = 0;   // read by the testbench

	idle_sioc_high: assert property (@(posedge clk) disable iff (!rst_n)
		(state_i == idle) |-> sioc_i)
		else begin
			fail_count++;
			$error("SIO_C low while the sequencer is idle");
		end

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done_i |=> !done_i)
		else begin
			fail_count++;
			$error("done_o longer than one cycle");
		end

	busy_ends_with_done: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy_i) |-> done_i)
		else begin
			fail_count++;
			$error("busy_o fell without done_o");
		end

	// slave owns SIO_D for the ack slot of a transmitted byte
	ack_slot_released: assert property (@(posedge clk) disable iff (!rst_n)
		(sample_i && last_bit_i && phase_kind_i != ph_rdata) |=> !siod_oe_i)
		else begin
			fail_count++;
			$error("master still drives SIO_D after the ack sample");
		end

endmodule

bind sccb_sequencer sccb_master_chk u_chk (
	.clk          (clk),
	.rst_n        (rst_n),
	.state_i      (state),
	.phase_kind_i (cur_ph),
	.sioc_i       (u_timer.sioc_o),
	.busy_i       (busy_o),
	.done_i       (done_o),
	.siod_oe_i    (siod_oe_o),
	.sample_i     (bus.sample),
	.last_bit_i   (bus.last_bit)
);

// File: bench/sccb_master_tb.sv
`timescale 1ns/1ps

module sccb_master_tb;
	import sccb_pkg::*;

	localparam int CLK_DIV  = SCCB_CLK_DIV_DEF;
	localparam int N_RANDOM = 40;
	localparam int N_TXN    = N_RANDOM + 5;
	localparam int BIT_NS   = 4 * CLK_DIV * 4;
	localparam int TXN_BITS = 36 + 10;   // read length plus start, stop and gap
	localparam int S_MARK   = 256;       // start condition in the bus log
	localparam int P_MARK   = 512;       // stop condition

	logic       clk = 1'b0;
	logic       rst_n;
	logic       start_i;
	logic       rw_i;
	logic [7:0] id_i;
	logic [7:0] reg_i;
	logic [7:0] wdata_i;
	logic       sioc_o;
	logic       siod_o;
	logic       siod_oe_o;
	logic       busy_o;
	logic       done_o;
	logic       ack_error_o;
	logic [7:0] rdata_o;

	logic       sda;             // resolved SIO_D
	logic       cam_drv = 1'b1;  // camera pull-down with 1 as released
	integer     seed = 75;
	int         dones = 0;
	logic [7:0] ref_mem [256];

	// camera model
	logic [7:0] cam_mem [256];
	int         bus_log [$];
	bit         in_txn = 1'b0;
	bit         reading = 1'b0;
	int         bit_n = 0;
	int         byte_n = 0;
	int         starts = 0;
	int         withhold_byte = -1;
	logic [7:0] cur_byte;
	logic [7:0] rd_val;
	logic [7:0] reg_ptr;
	logic       na_level;

	sccb_master #(
		.CLK_DIV (CLK_DIV)
	) UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.start_i     (start_i),
		.rw_i        (rw_i),
		.id_i        (id_i),
		.reg_i       (reg_i),
		.wdata_i     (wdata_i),
		.siod_i      (sda),
		.sioc_o      (sioc_o),
		.siod_o      (siod_o),
		.siod_oe_o   (siod_oe_o),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.ack_error_o (ack_error_o),
		.rdata_o     (rdata_o)
	);

	always #2 clk = ~clk;

	assign sda = (siod_oe_o ? siod_o : 1'b1) & cam_drv;   // wired-AND with pull-up

	always @(posedge done_o) begin
		dones++;
	end

	always @(negedge sda) begin
		if (rst_n === 1'b1 && sioc_o === 1'b1) begin   // start condition
			in_txn  = 1'b1;
			reading = 1'b0;
			bit_n   = 0;
			byte_n  = 0;
			starts++;
			bus_log.push_back(S_MARK);
		end
	end

	always @(posedge sda) begin
		if (rst_n === 1'b1 && sioc_o === 1'b1 && in_txn) begin   // stop condition
			in_txn = 1'b0;
			bus_log.push_back(P_MARK);
		end
	end

	always @(posedge sioc_o) begin
		if (in_txn && bit_n < 8) begin
			cur_byte = {cur_byte[6:0], sda};
			bit_n++;
			if (bit_n == 8) begin
				bus_log.push_back(cur_byte);
				if (byte_n == 0) begin
					reading = cur_byte[0];
					rd_val  = cam_mem[reg_ptr];
				end else if (byte_n == 1 && !reading) begin
					reg_ptr = cur_byte;
				end else if (byte_n == 2 && !reading) begin
					cam_mem[reg_ptr] = cur_byte;
				end
			end
		end else if (in_txn) begin
			if (reading && byte_n == 1) na_level = sda;   // master NA bit
			bit_n = 0;
			byte_n++;
		end
	end

	// camera changes SIO_D only while SIO_C is low
	always @(negedge sioc_o) begin
		cam_drv = 1'b1;
		if (in_txn && bit_n == 8) begin
			if (!(reading && byte_n == 1) && byte_n != withhold_byte) cam_drv = 1'b0;
		end else if (in_txn && reading && byte_n == 1) begin
			cam_drv = rd_val[7 - bit_n];
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic run_txn(input logic rw, input logic [7:0] id, input logic [7:0] rg,
			input logic [7:0] wd, input bit noise);
		int exp_log [$];
		int i;
		bus_log.delete();
		na_level = 1'bx;
		exp_log = {S_MARK, int'({id[7:1], 1'b0}), int'(rg)};
		if (rw) begin
			exp_log = {exp_log, P_MARK, S_MARK, int'({id[7:1], 1'b1}), int'(ref_mem[rg])};
		end else begin
			exp_log.push_back(wd);
			ref_mem[rg] = wd;
		end
		exp_log.push_back(P_MARK);

		@(posedge clk);
		#1;
		start_i = 1'b1;
		rw_i    = rw;
		id_i    = id;
		reg_i   = rg;
		wdata_i = wd;
		@(posedge clk);
		#1;
		start_i = 1'b0;
		assert (busy_o === 1'b1 && ack_error_o === 1'b0) else abort_run($sformatf(
			"[ERROR] t=%0t: busy %b ack_error %b after start", $time, busy_o, ack_error_o));
		while (done_o !== 1'b1) begin
			@(posedge clk);
			#1;
			start_i = noise && busy_o && (($random(seed) & 7) == 0);   // ignored strobe
			if (start_i) begin
				rw_i  = $random(seed);
				id_i  = $random(seed);
				reg_i = $random(seed);
			end
		end

		assert (busy_o === 1'b0) else abort_run($sformatf(
			"[ERROR] t=%0t: busy_o still high with done_o", $time));
		assert (bus_log.size() == exp_log.size()) else abort_run($sformatf(
			"[ERROR] t=%0t: camera saw %0d bus events, expected %0d",
			$time, bus_log.size(), exp_log.size()));
		for (i = 0; i < exp_log.size(); i++) begin
			assert (bus_log[i] == exp_log[i]) else abort_run($sformatf(
				"[ERROR] t=%0t: bus event %0d is 0x%0h, expected 0x%0h",
				$time, i, bus_log[i], exp_log[i]));
		end
		if (rw) begin
			assert (rdata_o === ref_mem[rg] && na_level === 1'b1) else abort_run($sformatf(
				"[ERROR] t=%0t: reg 0x%02h read 0x%02h NA %b, expected 0x%02h NA 1",
				$time, rg, rdata_o, na_level, ref_mem[rg]));
		end else begin
			assert (cam_mem[rg] === wd) else abort_run($sformatf(
				"[ERROR] t=%0t: camera reg 0x%02h holds 0x%02h, expected 0x%02h",
				$time, rg, cam_mem[rg], wd));
		end
		if (withhold_byte < 0) begin
			assert (ack_error_o === 1'b0) else abort_run($sformatf(
				"[ERROR] t=%0t: ack_error_o set with every byte acked", $time));
		end
	endtask

	always @(UUT.u_seq.u_chk.fail_count) begin
		if (UUT.u_seq.u_chk.fail_count != 0) abort_run("protocol checker flagged a violation");
	end

	initial begin
		#(N_TXN * TXN_BITS * BIT_NS);
		abort_run("watchdog expired, a transfer never finished");
	end

	initial begin
		logic       rw;
		logic [7:0] id;
		logic [7:0] rg;
		logic [7:0] wd;
		int         n_reads;
		int         starts0;
		int         dones0;
		rst_n   = 1'b0;
		start_i = 1'b0;
		rw_i    = 1'b0;
		id_i    = 8'h00;
		reg_i   = 8'h00;
		wdata_i = 8'h00;
		for (int a = 0; a < 256; a++) begin
			ref_mem[a] = 8'(a * 29 + 60);   // odd multiplier gives each address its own value
			cam_mem[a] = ref_mem[a];
		end
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		repeat (2) @(posedge clk);
		#1;

		// idle bus after reset
		assert (sioc_o === 1'b1 && siod_o === 1'b1 && siod_oe_o === 1'b1) else abort_run(
			$sformatf("[ERROR] t=%0t: idle bus sioc %b siod %b oe %b",
			$time, sioc_o, siod_o, siod_oe_o));
		assert (busy_o === 1'b0 && done_o === 1'b0 && ack_error_o === 1'b0 &&
			rdata_o === 8'h00 && starts == 0) else abort_run($sformatf(
			"[ERROR] t=%0t: control outputs not at reset values", $time));

		id = $random(seed) & 8'hfe;
		rg = $random(seed);
		wd = $random(seed);
		run_txn(1'b0, id, rg, wd, 1'b0);
		assert (dones == 1) else abort_run($sformatf(
			"[ERROR] t=%0t: %0d done pulses for one write", $time, dones));
		run_txn(1'b1, id, rg, 8'h00, 1'b0);           // written register
		run_txn(1'b1, id, rg ^ 8'h80, 8'h00, 1'b0);   // preset register

		// no ack on the register byte
		withhold_byte = 1;
		run_txn(1'b0, id, $random(seed), $random(seed), 1'b0);
		withhold_byte = -1;
		assert (ack_error_o === 1'b1) else abort_run($sformatf(
			"[ERROR] t=%0t: ack_error_o low after a missing ack", $time));
		run_txn(1'b0, id, $random(seed), $random(seed), 1'b0);

		n_reads = 0;
		starts0 = starts;
		dones0  = dones;
		repeat (N_RANDOM) begin
			rw = $random(seed);
			id = $random(seed);
			rg = $random(seed);
			wd = $random(seed);
			run_txn(rw, id, rg, wd, 1'b1);
			if (rw) n_reads++;
		end
		assert (starts - starts0 == N_RANDOM + n_reads && dones - dones0 == N_RANDOM)
			else abort_run($sformatf("[ERROR] t=%0t: %0d starts %0d dones, expected %0d and %0d",
			$time, starts - starts0, dones - dones0, N_RANDOM + n_reads, N_RANDOM));

		if (UUT.u_seq.u_chk.fail_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1);
		end
	end

endmodule

// File: build.f
source/sccb_pkg.sv
source/sccb_phase_if.sv
source/sccb_bit_timer.sv
source/sccb_shifter.sv
source/sccb_sequencer.sv
source/sccb_master.sv
bench/sccb_master_chk.sv
bench/sccb_master_tb.sv
